// File: b_unpacket.f
+incdir+design
design/packet_pkg.sv
design/unpack_ctrl_pkg.sv
design/unpack_fsm.sv
design/header_decoder.sv
design/rx_bram_reader.sv
design/sink_steer.sv
design/randombit_packer.sv
design/b_unpacket.sv
dv/tb_b_unpacket.sv

// File: design/b_unpacket.sv
`timescale 1ns/100ps
`default_nettype none

module b_unpacket (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 msg_accessed,
    input  logic                 busy_net2pp,
    output logic                 busy_pp2net,
    output packet_pkg::rx_addr_t rx_bram_addr,
    input  packet_pkg::word_t    rx_bram_dout,
    output logic                 er_fifo_wr_en,
    output packet_pkg::word_t    er_fifo_din,
    output logic                 decoy_fifo_wr_en,
    output packet_pkg::word_t    decoy_fifo_din,
    output logic                 ev_bram_we,
    output packet_pkg::rb_addr_t ev_bram_addr,
    output packet_pkg::rb_word_t ev_bram_din,
    input  logic                 reset_ev,
    output logic                 ev_full
);

    import packet_pkg::*;

    // fsm strobes
    logic     header_capture;
    logic     payload_run;
    logic     pkt_done;
    logic     payload_done;
    // decoded header
    sink_t    sink_sel;
    rx_addr_t depth;
    logic     header_included;
    // read path
    word_t    rd_data;
    word_t    word;
    logic     word_valid;
    // random-bit path
    word_t    rb_word;
    logic     rb_word_valid;
    logic     rb_pkt_done;

    unpack_fsm i_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .msg_accessed   (msg_accessed),
        .busy_net2pp    (busy_net2pp),
        .payload_done   (payload_done),
        .busy_pp2net    (busy_pp2net),
        .header_capture (header_capture),
        .payload_run    (payload_run),
        .pkt_done       (pkt_done)
    );

    header_decoder i_hdr (
        .clk             (clk),
        .rst_n           (rst_n),
        .header_capture  (header_capture),
        .pkt_done        (pkt_done),
        .rd_data         (rd_data),
        .sink_sel        (sink_sel),
        .depth           (depth),
        .header_included (header_included)
    );

    rx_bram_reader i_reader (
        .clk             (clk),
        .rst_n           (rst_n),
        .payload_run     (payload_run),
        .pkt_done        (pkt_done),
        .depth           (depth),
        .header_included (header_included),
        .rx_bram_dout    (rx_bram_dout),
        .rx_bram_addr    (rx_bram_addr),
        .rd_data         (rd_data),
        .word            (word),
        .word_valid      (word_valid),
        .payload_done    (payload_done)
    );

    sink_steer i_steer (
        .clk              (clk),
        .rst_n            (rst_n),
        .sink_sel         (sink_sel),
        .word             (word),
        .word_valid       (word_valid),
        .pkt_done         (pkt_done),
        .er_fifo_wr_en    (er_fifo_wr_en),
        .er_fifo_din      (er_fifo_din),
        .decoy_fifo_wr_en (decoy_fifo_wr_en),
        .decoy_fifo_din   (decoy_fifo_din),
        .rb_word          (rb_word),
        .rb_word_valid    (rb_word_valid),
        .rb_pkt_done      (rb_pkt_done)
    );

    randombit_packer i_packer (
        .clk           (clk),
        .rst_n         (rst_n),
        .rb_word       (rb_word),
        .rb_word_valid (rb_word_valid),
        .rb_pkt_done   (rb_pkt_done),
        .reset_ev      (reset_ev),
        .ev_bram_we    (ev_bram_we),
        .ev_bram_addr  (ev_bram_addr),
        .ev_bram_din   (ev_bram_din),
        .ev_full       (ev_full)
    );

endmodule

`default_nettype wire

// File: design/header_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "unpack_consts.svh"

module header_decoder (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                header_capture,
    input  logic                pkt_done,
    input  packet_pkg::word_t   rd_data,
    output packet_pkg::sink_t   sink_sel,
    output packet_pkg::rx_addr_t depth,
    output logic                header_included
);

    import packet_pkg::*;

    // short length field sits right below the length code
    localparam int SHORT_LEN_W = 9;
    localparam int LEN_CODE_LSB = `WORD_W - `TYPE_W - `LEN_CODE_W;

    word_t                  header_q;
    logic [`TYPE_W-1:0]     pkt_type;
    logic [`LEN_CODE_W-1:0] len_code;
    logic [SHORT_LEN_W-1:0] short_len;

    // header held for the whole packet
    always_ff @(posedge clk) begin
        if (!rst_n || pkt_done) begin
            header_q <= '0;
        end else if (header_capture) begin
            header_q <= rd_data;
        end
    end

    assign pkt_type  = header_q[`WORD_W-1 -: `TYPE_W];
    assign len_code  = header_q[LEN_CODE_LSB +: `LEN_CODE_W];
    assign short_len = header_q[LEN_CODE_LSB-1 -: SHORT_LEN_W];

    // type to sink, unknown types go nowhere
    always_comb begin
        case (pkt_type)
            `TYPE_CORRECT_PARITY: sink_sel = SINK_ER;
            `TYPE_TARGET_HASHTAG: sink_sel = SINK_ER;
            `TYPE_Z_BASIS_DECOY:  sink_sel = SINK_DECOY;
            `TYPE_EV_RANDOMBIT:   sink_sel = SINK_RB;
            default:              sink_sel = SINK_NONE;
        endcase
    end

    // error-correction packets carry the header into the fifo
    assign header_included = (sink_sel == SINK_ER);

    // length code to payload depth
    always_comb begin
        case (len_code)
            `LEN_257:  depth = rx_addr_t'(short_len);
            `LEN_514:  depth = `DEPTH_514;
            `LEN_771:  depth = `DEPTH_771;
            `LEN_1028: depth = `DEPTH_1028;
            default:   depth = `DEPTH_1028;
        endcase
    end

endmodule

`default_nettype wire

// File: design/packet_pkg.sv
`default_nettype none

`include "unpack_consts.svh"

package packet_pkg;

    // one receive ram word
    typedef logic [`WORD_W-1:0] word_t;

    // receive ram address, also the payload depth
    typedef logic [`RX_ADDR_W-1:0] rx_addr_t;

    // random-bit ram address and packed data
    typedef logic [`RB_ADDR_W-1:0] rb_addr_t;
    typedef logic [2*`WORD_W-1:0] rb_word_t;

    // where payload words go
    typedef enum logic [1:0] {
        SINK_NONE  = 2'd0,
        SINK_ER    = 2'd1,
        SINK_DECOY = 2'd2,
        SINK_RB    = 2'd3
    } sink_t;

endpackage

`default_nettype wire

// File: design/randombit_packer.sv
`timescale 1ns/100ps
`default_nettype none

`include "unpack_consts.svh"

module randombit_packer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  packet_pkg::word_t    rb_word,
    input  logic                 rb_word_valid,
    input  logic                 rb_pkt_done,
    input  logic                 reset_ev,
    output logic                 ev_bram_we,
    output packet_pkg::rb_addr_t ev_bram_addr,
    output packet_pkg::rb_word_t ev_bram_din,
    output logic                 ev_full
);

    import packet_pkg::*;

    localparam int CNT_W = $clog2(`EV_FULL_PACKETS + 1);

    word_t            hi_word;
    // set while the first word of a pair is held
    logic             pair_sel;
    logic [CNT_W-1:0] pkt_cnt;

    // first word of each pair
    always_ff @(posedge clk) begin
        if (rb_word_valid && !pair_sel) begin
            hi_word <= rb_word;
        end
    end

    // pair toggle, an odd trailing word is dropped at packet end
    always_ff @(posedge clk) begin
        if (!rst_n || rb_pkt_done) begin
            pair_sel <= 1'b0;
        end else if (rb_word_valid) begin
            pair_sel <= !pair_sel;
        end
    end

    // write on the second word, earlier word in the upper half
    assign ev_bram_we  = rb_word_valid && pair_sel;
    assign ev_bram_din = ev_bram_we ? {hi_word, rb_word} : '0;

    // write address, wraps at the top of the ram
    always_ff @(posedge clk) begin
        if (!rst_n || reset_ev) begin
            ev_bram_addr <= '0;
        end else if (ev_bram_we) begin
            ev_bram_addr <= ev_bram_addr + 1'b1;
        end
    end

    // stored packets, holds at the full mark
    always_ff @(posedge clk) begin
        if (!rst_n || reset_ev) begin
            pkt_cnt <= '0;
        end else if (rb_pkt_done && !ev_full) begin
            pkt_cnt <= pkt_cnt + 1'b1;
        end
    end

    assign ev_full = (pkt_cnt == CNT_W'(`EV_FULL_PACKETS));

endmodule

`default_nettype wire

// File: design/rx_bram_reader.sv
`timescale 1ns/100ps
`default_nettype none

module rx_bram_reader (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 payload_run,
    input  logic                 pkt_done,
    input  packet_pkg::rx_addr_t depth,
    input  logic                 header_included,
    input  packet_pkg::word_t    rx_bram_dout,
    output packet_pkg::rx_addr_t rx_bram_addr,
    output packet_pkg::word_t    rd_data,
    output packet_pkg::word_t    word,
    output logic                 word_valid,
    output logic                 payload_done
);

    import packet_pkg::*;

    rx_addr_t issue_cnt;
    logic     issue_done;
    logic     issuing;
    logic     issue_last;
    // first pipeline stage, lines up with ram latency
    logic     valid_s1;
    logic     last_s1;
    // second stage, lines up with rd_data
    logic     last_s2;

    assign issuing    = payload_run && !issue_done;
    assign issue_last = issuing && (issue_cnt == depth);

    // address 0 outside the payload phase keeps the header on rd_data
    assign rx_bram_addr = issuing ? issue_cnt : '0;

    // issue counter, addresses 0 through depth
    always_ff @(posedge clk) begin
        if (!rst_n || pkt_done) begin
            issue_cnt  <= '0;
            issue_done <= 1'b0;
        end else if (issuing) begin
            issue_cnt <= issue_cnt + 1'b1;
            if (issue_last) begin
                issue_done <= 1'b1;
            end
        end
    end

    // registered ram output
    always_ff @(posedge clk) begin
        rd_data <= rx_bram_dout;
    end

    // valid and last travel two cycles behind the address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_s1     <= 1'b0;
            last_s1      <= 1'b0;
            word_valid   <= 1'b0;
            last_s2      <= 1'b0;
            payload_done <= 1'b0;
        end else begin
            // address 0 is the header, only passed on when wanted
            valid_s1     <= issuing && ((issue_cnt != '0) || header_included);
            last_s1      <= issue_last;
            word_valid   <= valid_s1;
            last_s2      <= last_s1;
            // one cycle after the last word
            payload_done <= last_s2;
        end
    end

    assign word = word_valid ? rd_data : '0;

endmodule

`default_nettype wire

// File: design/sink_steer.sv
`timescale 1ns/100ps
`default_nettype none

module sink_steer (
    input  logic              clk,
    input  logic              rst_n,
    input  packet_pkg::sink_t sink_sel,
    input  packet_pkg::word_t word,
    input  logic              word_valid,
    input  logic              pkt_done,
    output logic              er_fifo_wr_en,
    output packet_pkg::word_t er_fifo_din,
    output logic              decoy_fifo_wr_en,
    output packet_pkg::word_t decoy_fifo_din,
    output packet_pkg::word_t rb_word,
    output logic              rb_word_valid,
    output logic              rb_pkt_done
);

    import packet_pkg::*;

    // one data register shared by all sinks
    word_t word_q;

    always_ff @(posedge clk) begin
        word_q <= word;
    end

    // at most one enable per valid word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            er_fifo_wr_en    <= 1'b0;
            decoy_fifo_wr_en <= 1'b0;
            rb_word_valid    <= 1'b0;
            rb_pkt_done      <= 1'b0;
        end else begin
            er_fifo_wr_en    <= word_valid && (sink_sel == SINK_ER);
            decoy_fifo_wr_en <= word_valid && (sink_sel == SINK_DECOY);
            rb_word_valid    <= word_valid && (sink_sel == SINK_RB);
            // packer only counts random-bit packets
            rb_pkt_done      <= pkt_done && (sink_sel == SINK_RB);
        end
    end

    // data is zero whenever its strobe is low
    assign er_fifo_din    = er_fifo_wr_en ? word_q : '0;
    assign decoy_fifo_din = decoy_fifo_wr_en ? word_q : '0;
    assign rb_word        = rb_word_valid ? word_q : '0;

endmodule

`default_nettype wire

// File: design/unpack_consts.svh
`ifndef UNPACK_CONSTS_SVH
`define UNPACK_CONSTS_SVH

// receive data word and ram widths
`define WORD_W 32
`define RX_ADDR_W 11
`define RB_ADDR_W 14

// header field widths
`define TYPE_W 4
`define LEN_CODE_W 4

// packet type codes, header bits 31 to 28
`define TYPE_CORRECT_PARITY 4'd1
`define TYPE_TARGET_HASHTAG 4'd2
`define TYPE_Z_BASIS_DECOY 4'd3
`define TYPE_EV_RANDOMBIT 4'd4

// length codes, header bits 27 to 24
// 257 code takes the short length from bits 23 to 15
`define LEN_257 4'd0
`define LEN_514 4'd1
`define LEN_771 4'd2
`define LEN_1028 4'd3

// payload depths for the fixed codes
`define DEPTH_514 11'd512
`define DEPTH_771 11'd768
`define DEPTH_1028 11'd1024

// stored random-bit packets that mean the ram is full
`define EV_FULL_PACKETS 32

`endif

// File: design/unpack_ctrl_pkg.sv
`default_nettype none

package unpack_ctrl_pkg;

    // packet phases of the unpacker
    typedef enum logic [2:0] {
        ST_IDLE          = 3'd0,
        ST_READ_HDR      = 3'd1,
        ST_SET_PARAM     = 3'd2,
        ST_WRITE_PAYLOAD = 3'd3,
        ST_UNPACK_DONE   = 3'd4,
        // network side still holds msg_accessed
        ST_WAIT_RELEASE  = 3'd5
    } unpack_state_t;

endpackage

`default_nettype wire

// File: design/unpack_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module unpack_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic msg_accessed,
    input  logic busy_net2pp,
    input  logic payload_done,
    output logic busy_pp2net,
    output logic header_capture,
    output logic payload_run,
    output logic pkt_done
);

    import unpack_ctrl_pkg::*;

    unpack_state_t state;
    unpack_state_t state_next;

    // next state
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                // busy_net2pp is the only back-pressure
                if (msg_accessed && !busy_net2pp) begin
                    state_next = ST_READ_HDR;
                end
            end
            ST_READ_HDR: begin
                state_next = ST_SET_PARAM;
            end
            // one cycle for the decoded depth to settle
            ST_SET_PARAM: begin
                state_next = ST_WRITE_PAYLOAD;
            end
            ST_WRITE_PAYLOAD: begin
                if (payload_done) begin
                    state_next = ST_UNPACK_DONE;
                end
            end
            ST_UNPACK_DONE: begin
                state_next = ST_WAIT_RELEASE;
            end
            ST_WAIT_RELEASE: begin
                if (!msg_accessed) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // state and strobes, registered off the next state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            busy_pp2net    <= 1'b0;
            header_capture <= 1'b0;
            payload_run    <= 1'b0;
            pkt_done       <= 1'b0;
        end else begin
            state          <= state_next;
            busy_pp2net    <= (state_next != ST_IDLE);
            header_capture <= (state_next == ST_READ_HDR);
            payload_run    <= (state_next == ST_WRITE_PAYLOAD);
            pkt_done       <= (state_next == ST_UNPACK_DONE);
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_b_unpacket.sv
`timescale 1ns/100ps
`default_nettype none

`include "unpack_consts.svh"

module tb_b_unpacket;

    import packet_pkg::*;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     msg_accessed;
    logic     busy_net2pp;
    logic     busy_pp2net;
    rx_addr_t rx_bram_addr;
    word_t    rx_bram_dout;
    logic     er_fifo_wr_en;
    word_t    er_fifo_din;
    logic     decoy_fifo_wr_en;
    word_t    decoy_fifo_din;
    logic     ev_bram_we;
    rb_addr_t ev_bram_addr;
    rb_word_t ev_bram_din;
    logic     reset_ev;
    logic     ev_full;

    // receive ram model
    word_t    rx_mem [0:(1 << `RX_ADDR_W) - 1];
    rx_addr_t ram_addr_q;

    // expected writes in one queue per sink
    word_t    er_q[$];
    word_t    decoy_q[$];
    rb_word_t ev_data_q[$];
    rb_addr_t ev_addr_q[$];

    // current queue heads seen by the assertions
    logic     er_have = 1'b0;
    word_t    er_exp = '0;
    logic     decoy_have = 1'b0;
    word_t    decoy_exp = '0;
    logic     ev_have = 1'b0;
    rb_word_t ev_data_exp = '0;
    rb_addr_t ev_addr_exp = '0;
    int       pending = 0;

    // set while busy_net2pp holds off a waiting packet
    logic        hold_check;
    logic [31:0] rng_state;
    rb_addr_t    rb_addr_model;
    longint      budget_ns = 2000;

    always #2 clk = ~clk;

    b_unpacket i_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .msg_accessed     (msg_accessed),
        .busy_net2pp      (busy_net2pp),
        .busy_pp2net      (busy_pp2net),
        .rx_bram_addr     (rx_bram_addr),
        .rx_bram_dout     (rx_bram_dout),
        .er_fifo_wr_en    (er_fifo_wr_en),
        .er_fifo_din      (er_fifo_din),
        .decoy_fifo_wr_en (decoy_fifo_wr_en),
        .decoy_fifo_din   (decoy_fifo_din),
        .ev_bram_we       (ev_bram_we),
        .ev_bram_addr     (ev_bram_addr),
        .ev_bram_din      (ev_bram_din),
        .reset_ev         (reset_ev),
        .ev_full          (ev_full)
    );

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic step();
        @(posedge clk);
        #0.5;
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, got);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // payload words behind the header by length code
    function automatic int payload_depth(input logic [3:0] code, input logic [8:0] short_len);
        case (code)
            `LEN_257:  return int'(short_len);
            `LEN_514:  return int'(`DEPTH_514);
            `LEN_771:  return int'(`DEPTH_771);
            `LEN_1028: return int'(`DEPTH_1028);
            default:   return int'(`DEPTH_1028);
        endcase
    endfunction

    // one cycle read latency with the address taken mid-cycle
    initial begin
        rx_bram_dout = '0;
        forever begin
            @(negedge clk);
            ram_addr_q = rx_bram_addr;
            @(posedge clk);
            #0.5;
            rx_bram_dout = rx_mem[ram_addr_q];
        end
    end

    // retire the write just checked and show the next one
    always @(negedge clk) begin
        #0.5;
        if (er_fifo_wr_en && er_q.size() != 0) begin
            void'(er_q.pop_front());
        end
        if (decoy_fifo_wr_en && decoy_q.size() != 0) begin
            void'(decoy_q.pop_front());
        end
        if (ev_bram_we && ev_data_q.size() != 0) begin
            void'(ev_data_q.pop_front());
            void'(ev_addr_q.pop_front());
        end
        er_have     = (er_q.size() != 0);
        er_exp      = er_have ? er_q[0] : '0;
        decoy_have  = (decoy_q.size() != 0);
        decoy_exp   = decoy_have ? decoy_q[0] : '0;
        ev_have     = (ev_data_q.size() != 0);
        ev_data_exp = ev_have ? ev_data_q[0] : '0;
        ev_addr_exp = ev_have ? ev_addr_q[0] : '0;
        pending     = er_q.size() + decoy_q.size() + ev_data_q.size();
    end

    // sink writes against the queue heads
    assert property (@(negedge clk) disable iff (!rst_n)
        er_fifo_wr_en |-> (er_have && er_fifo_din == er_exp))
    else begin
        $display("FAIL t=%0t er_fifo_din expected %h got %h, %0d queued",
                 $time, er_exp, er_fifo_din, er_q.size());
        abort_run();
    end

    assert property (@(negedge clk) disable iff (!rst_n)
        decoy_fifo_wr_en |-> (decoy_have && decoy_fifo_din == decoy_exp))
    else begin
        $display("FAIL t=%0t decoy_fifo_din expected %h got %h, %0d queued",
                 $time, decoy_exp, decoy_fifo_din, decoy_q.size());
        abort_run();
    end

    assert property (@(negedge clk) disable iff (!rst_n)
        ev_bram_we |-> (ev_have && ev_bram_din == ev_data_exp))
    else begin
        $display("FAIL t=%0t ev_bram_din expected %h got %h, %0d queued",
                 $time, ev_data_exp, ev_bram_din, ev_data_q.size());
        abort_run();
    end

    assert property (@(negedge clk) disable iff (!rst_n)
        ev_bram_we |-> (ev_bram_addr == ev_addr_exp))
    else begin
        $display("FAIL t=%0t ev_bram_addr expected %0d got %0d",
                 $time, ev_addr_exp, ev_bram_addr);
        abort_run();
    end

    // handshake rules
    assert property (@(negedge clk) disable iff (!rst_n)
        hold_check |-> (!busy_pp2net && rx_bram_addr == '0))
    else begin
        $display("packet started at %0t while busy_net2pp was high", $time);
        abort_run();
    end

    assert property (@(negedge clk) disable iff (!rst_n)
        $fell(busy_pp2net) |-> !msg_accessed)
    else begin
        $display("busy_pp2net fell at %0t with msg_accessed still high", $time);
        abort_run();
    end

    assert property (@(negedge clk) disable iff (!rst_n)
        $fell(busy_pp2net) |-> (pending == 0))
    else begin
        $display("packet ended at %0t with %0d expected writes missing", $time, pending);
        abort_run();
    end

    // loads one packet and queues its expected writes before the handshake
    task automatic run_packet(input logic [3:0] ptype, input logic [3:0] code,
                              input logic [8:0] short_len, input int block_cycles,
                              input int hold_cycles);
        int    n;
        word_t w;
        word_t hi;
        n = payload_depth(code, short_len);
        // header with random filler in the low bits
        rng_state = xorshift32(rng_state);
        w = {ptype, code, short_len, rng_state[14:0]};
        rx_mem[0] = w;
        if (ptype == `TYPE_CORRECT_PARITY || ptype == `TYPE_TARGET_HASHTAG) begin
            er_q.push_back(w);
        end
        for (int i = 1; i <= n; i++) begin
            rng_state = xorshift32(rng_state);
            w = rng_state;
            rx_mem[i] = w;
            case (ptype)
                `TYPE_CORRECT_PARITY, `TYPE_TARGET_HASHTAG: er_q.push_back(w);
                `TYPE_Z_BASIS_DECOY: decoy_q.push_back(w);
                `TYPE_EV_RANDOMBIT: begin
                    // earlier word of a pair goes high and an odd tail is dropped
                    if (i % 2 == 1) begin
                        hi = w;
                    end else begin
                        ev_data_q.push_back({hi, w});
                        ev_addr_q.push_back(rb_addr_model);
                        rb_addr_model = rb_addr_model + rb_addr_t'(1);
                    end
                end
                default: begin
                end
            endcase
        end
        budget_ns = budget_ns + 8 * (n + 1) + 2000;
        // ram settles two cycles before the start
        step();
        step();
        msg_accessed = 1'b1;
        if (block_cycles > 0) begin
            busy_net2pp = 1'b1;
            hold_check  = 1'b1;
            repeat (block_cycles) step();
            busy_net2pp = 1'b0;
            hold_check  = 1'b0;
        end
        while (!busy_pp2net) begin
            step();
        end
        repeat (hold_cycles) step();
        check_bit("busy_pp2net", 1'b1, busy_pp2net);
        msg_accessed = 1'b0;
        while (busy_pp2net) begin
            step();
        end
        step();
    endtask

    // budget grows as packets are queued
    initial begin
        while ($time <= budget_ns) begin
            #100;
        end
        $display("watchdog expired at %0t, the DUT stopped making progress", $time);
        abort_run();
    end

    initial begin
        rst_n         = 1'b0;
        msg_accessed  = 1'b0;
        busy_net2pp   = 1'b0;
        reset_ev      = 1'b0;
        hold_check    = 1'b0;
        rng_state     = 32'd78;
        rb_addr_model = '0;
        // fill pattern follows the whole address
        for (int a = 0; a < (1 << `RX_ADDR_W); a++) begin
            rx_mem[a] = 32'hbad0_0000 ^ 32'(a);
        end
        repeat (8) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        // quiet outputs out of reset
        check_bit("busy_pp2net", 1'b0, busy_pp2net);
        check_bit("er_fifo_wr_en", 1'b0, er_fifo_wr_en);
        check_bit("decoy_fifo_wr_en", 1'b0, decoy_fifo_wr_en);
        check_bit("ev_bram_we", 1'b0, ev_bram_we);
        check_bit("ev_full", 1'b0, ev_full);
        // header before payload
        run_packet(`TYPE_CORRECT_PARITY, `LEN_257, 9'd20, 0, 0);
        // msg_accessed held well past the packet end
        run_packet(`TYPE_TARGET_HASHTAG, `LEN_257, 9'd20, 0, 60);
        // held off by busy_net2pp for a while
        run_packet(`TYPE_Z_BASIS_DECOY, `LEN_514, 9'd0, 20, 0);
        // unknown type and length code are read through
        run_packet(4'hf, 4'h9, 9'd0, 0, 0);
        run_packet(`TYPE_EV_RANDOMBIT, `LEN_257, 9'd7, 0, 0);
        for (int k = 2; k <= 31; k++) begin
            run_packet(`TYPE_EV_RANDOMBIT, `LEN_257, 9'd2, 0, 0);
        end
        check_bit("ev_full", 1'b0, ev_full);
        run_packet(`TYPE_EV_RANDOMBIT, `LEN_257, 9'd2, 0, 0);
        check_bit("ev_full", 1'b1, ev_full);
        // count holds at full
        run_packet(`TYPE_EV_RANDOMBIT, `LEN_257, 9'd2, 0, 0);
        check_bit("ev_full", 1'b1, ev_full);
        // clear count and address
        reset_ev = 1'b1;
        step();
        reset_ev = 1'b0;
        rb_addr_model = '0;
        step();
        check_bit("ev_full", 1'b0, ev_full);
        run_packet(`TYPE_EV_RANDOMBIT, `LEN_257, 9'd4, 0, 0);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the b_unpacket testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_b_unpacket -Mdir obj_dir -f b_unpacket.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_b_unpacket > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx ">>> PASS" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
